// ==== Bender.yml ====
package:
  name: vec_reg_file

sources:
  # Packages first, the arbiter package depends on the geometry package
  - hdl/vecGeomPkg.sv
  - hdl/vecWritePkg.sv
  # Design sources, top level last
  - hdl/vecWriteArbiter.sv
  - hdl/vecLaneBank.sv
  - hdl/vecReadBypass.sv
  - hdl/vecRegFile.sv
  # Testbench, top module vecRegFileTb
  - target: test
    files:
      - dv/vecRegFileTb.sv

// ==== compile.f ====
hdl/vecGeomPkg.sv
hdl/vecWritePkg.sv
hdl/vecWriteArbiter.sv
hdl/vecLaneBank.sv
hdl/vecReadBypass.sv
hdl/vecRegFile.sv
dv/vecRegFileTb.sv

// ==== dv/vecRegFileTb.sv ====
// ==========================================================
// Self-checking testbench for the vector register file
// A shadow model applies the masked write rule per lane and
// forms the expected read data, same-cycle bypass included
// Concurrent assertions compare every port and lane on every
// clock edge, directed phases run first, then random traffic
// ==========================================================

`timescale 1ns/1ps

module vecRegFileTb;
	import vecGeomPkg::*;

	// Length of the random phase
	localparam int randomCycles = 2000;

	// Reset and the directed phases take well under 1000 cycles
	localparam int watchdogCycles = randomCycles + 1000;

	logic clk = 1'b0;
	logic reset;
	logic wr0;
	regAddr wa0;
	laneMask m0;
	logic z0;
	vecWord i0;
	logic wr1;
	regAddr wa1;
	laneMask m1;
	logic z1;
	vecWord i1;
	readAddrVec readAddr;
	readDataVec readData;

	// Shadow storage and its value after this cycle's writes
	vecWord shadow [regCount];
	vecWord afterWrite [regCount];

	// Expected read data for every port and lane
	readDataVec expData;

	vecRegFile uut (
		.clk(clk), .reset(reset),
		.wr0(wr0), .wa0(wa0), .m0(m0), .z0(z0), .i0(i0),
		.wr1(wr1), .wa1(wa1), .m1(m1), .z1(z1), .i1(i1),
		.readAddr(readAddr), .readData(readData)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// ==========================================================
	// Shadow model
	// ==========================================================

	// Port 0 is applied first and port 1 on top of it, so port 1 wins every lane it touches
	always_comb begin
		for (int r = 0; r < regCount; r++) begin
			afterWrite[r] = shadow[r];
			for (int l = 0; l < laneCount; l++) begin
				if (wr0 && wa0 == r && (m0[l] || z0))
					afterWrite[r][l] = m0[l] ? i0[l] : '0;
				if (wr1 && wa1 == r && (m1[l] || z1))
					afterWrite[r][l] = m1[l] ? i1[l] : '0;
			end
		end
		// A read sees the value after the writes, register 0 is always zero
		for (int p = 0; p < readPortCount; p++)
			expData[p] = (readAddr[p] == '0) ? '0 : afterWrite[readAddr[p]];
	end

	always @(posedge clk) begin
		for (int r = 0; r < regCount; r++)
			shadow[r] <= reset ? '0 : afterWrite[r];
	end

	// One assertion per read port and lane
	for (genvar p = 0; p < readPortCount; p++) begin : gPort
		for (genvar l = 0; l < laneCount; l++) begin : gLane
			readMatch : assert property (
				@(posedge clk) disable iff (reset) readData[p][l] == expData[p][l]
			) else begin
				$display("CHECK FAILED readData port %0d lane %0d got %h expected %h",
					p, l, $sampled(readData[p][l]), $sampled(expData[p][l]));
				$display("TESTS FAILED");
				$fatal(1);
			end
		end
	end

	// ==========================================================
	// Stimulus helpers
	// ==========================================================

	function automatic vecWord randWord();
		vecWord w;
		for (int l = 0; l < laneCount; l++)
			w[l] = {$urandom, $urandom};
		return w;
	endfunction

	// Half the addresses come from a small pool so the ports collide often
	function automatic regAddr pickAddr();
		return ($urandom_range(0, 1) == 1) ? regAddr'($urandom_range(0, 3))
			: regAddr'($urandom_range(0, regCount - 1));
	endfunction

	function automatic readAddrVec allPorts(input regAddr a);
		readAddrVec v;
		for (int p = 0; p < readPortCount; p++)
			v[p] = a;
		return v;
	endfunction

	// Ports read consecutive registers starting at base
	function automatic readAddrVec spread(input int base);
		readAddrVec v;
		for (int p = 0; p < readPortCount; p++)
			v[p] = regAddr'(base + p);
		return v;
	endfunction

	task automatic drive(
		input logic w0, input regAddr a0, input laneMask k0, input logic f0, input vecWord d0,
		input logic w1, input regAddr a1, input laneMask k1, input logic f1, input vecWord d1,
		input readAddrVec ra
	);
		@(posedge clk);
		wr0 <= w0;
		wa0 <= a0;
		m0 <= k0;
		z0 <= f0;
		i0 <= d0;
		wr1 <= w1;
		wa1 <= a1;
		m1 <= k1;
		z1 <= f1;
		i1 <= d1;
		readAddr <= ra;
	endtask

	task automatic idle(input readAddrVec ra);
		drive(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, '0, 1'b0, '0, ra);
	endtask

	// ==========================================================
	// Test sequence
	// ==========================================================

	initial begin
		void'($urandom(32'h17e8_0a9a));
		reset = 1'b1;
		wr0 = 1'b0;
		wa0 = '0;
		m0 = '0;
		z0 = 1'b0;
		i0 = '0;
		wr1 = 1'b0;
		wa1 = '0;
		m1 = '0;
		z1 = 1'b0;
		i1 = '0;
		readAddr = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		// Everything reads zero, then full-mask writes on each port read back
		for (int b = 0; b < regCount; b += readPortCount)
			idle(spread(b));
		drive(1'b1, 5, '1, 1'b0, randWord(), 1'b0, '0, '0, 1'b0, '0, allPorts(5));
		idle(allPorts(5));
		drive(1'b0, '0, '0, 1'b0, '0, 1'b1, 6, '1, 1'b0, randWord(), allPorts(6));
		idle(spread(5));

		// Register 0 stays zero whatever is written to it
		drive(1'b1, 0, '1, 1'b0, randWord(), 1'b1, 0, 4'b0011, 1'b1, randWord(), allPorts(0));
		drive(1'b1, 0, '1, 1'b0, randWord(), 1'b0, '0, '0, 1'b0, '0, allPorts(0));
		idle(allPorts(0));

		// Partial masks, first keeping and then zeroing the other lanes
		drive(1'b1, 7, '1, 1'b0, randWord(), 1'b0, '0, '0, 1'b0, '0, allPorts(7));
		drive(1'b1, 7, 4'b0101, 1'b0, randWord(), 1'b0, '0, '0, 1'b0, '0, allPorts(7));
		idle(allPorts(7));
		drive(1'b0, '0, '0, 1'b0, '0, 1'b1, 7, 4'b0011, 1'b1, randWord(), allPorts(7));
		idle(allPorts(7));

		// Both ports on one register, port 1 lanes win and the rest take port 0
		drive(1'b1, 9, '1, 1'b0, randWord(), 1'b1, 9, 4'b0110, 1'b0, randWord(), allPorts(9));
		idle(allPorts(9));
		drive(1'b1, 9, 4'b1001, 1'b1, randWord(), 1'b1, 9, 4'b0010, 1'b0, randWord(),
			allPorts(9));
		idle(allPorts(9));
		drive(1'b1, 9, '1, 1'b0, randWord(), 1'b1, 9, '0, 1'b0, randWord(), allPorts(9));
		idle(allPorts(9));

		// Live bits split between the banks, then two writes seen on spread ports
		drive(1'b0, '0, '0, 1'b0, '0, 1'b1, 10, '1, 1'b0, randWord(), allPorts(10));
		drive(1'b1, 10, 4'b0101, 1'b0, randWord(), 1'b0, '0, '0, 1'b0, '0, allPorts(10));
		idle(allPorts(10));
		drive(1'b1, 11, '1, 1'b0, randWord(), 1'b1, 12, '1, 1'b0, randWord(), spread(9));
		idle(spread(5));
		idle(spread(10));

		// Random traffic on both write ports and all read ports
		for (int c = 0; c < randomCycles; c++) begin
			readAddrVec ra;
			for (int p = 0; p < readPortCount; p++)
				ra[p] = pickAddr();
			drive($urandom_range(0, 1), pickAddr(), laneMask'($urandom), $urandom_range(0, 1),
				randWord(), $urandom_range(0, 1), pickAddr(), laneMask'($urandom),
				$urandom_range(0, 1), randWord(), ra);
		end
		idle(spread(0));
		repeat (2) @(posedge clk);
		$display("TESTS PASSED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", watchdogCycles);
		$display("TESTS FAILED");
		$fatal(1);
	end

endmodule

// ==== hdl/vecGeomPkg.sv ====
// ==========================================================
// Geometry of the vector register file
// Holds the lane, register and read-port counts and the
// vector types built on them
// Modules import it inside their body and use scoped names
// in their port lists
// ==========================================================

package vecGeomPkg;

	// Four lanes, each one element wide
	localparam int laneCount = 4;

	// Architectural vector registers, register 0 reads as zero
	localparam int regCount = 32;

	// Combinational read ports
	localparam int readPortCount = 8;

	// Width of one lane element
	localparam int elemWidth = 64;

	// Register address wide enough for every register
	typedef logic [$clog2(regCount)-1:0] regAddr;

	// One element in one lane
	typedef logic [elemWidth-1:0] laneElem;

	// One enable bit per lane
	typedef logic [laneCount-1:0] laneMask;

	// A whole vector register, lane 0 in the low bits
	typedef laneElem [laneCount-1:0] vecWord;

	// All read addresses side by side, port 0 in the low bits
	typedef regAddr [readPortCount-1:0] readAddrVec;

	// All read results side by side
	typedef vecWord [readPortCount-1:0] readDataVec;

endpackage

// ==== hdl/vecLaneBank.sv ====
// ==========================================================
// Storage for one lane of the vector register file
// Bank A takes port 0 writes and bank B takes port 1 writes
// A live bit per register records which bank wrote last,
// so both ports can write in the same cycle without a
// second write port on either bank
// Reads are raw, with no bypass and no register 0 rule
// ==========================================================

`timescale 1ns/1ps

module vecLaneBank (
	input logic clk,
	input logic reset,
	input vecWritePkg::laneOp op0,
	input vecWritePkg::laneOp op1,
	input vecGeomPkg::regAddr wa0,
	input vecGeomPkg::regAddr wa1,
	input vecGeomPkg::laneElem i0,
	input vecGeomPkg::laneElem i1,
	input vecGeomPkg::readAddrVec readAddr,
	output vecGeomPkg::laneElem [vecGeomPkg::readPortCount-1:0] rawData
);
	import vecGeomPkg::*;
	import vecWritePkg::*;

	// Bank A is written only by port 0
	laneElem bankA [regCount];

	// Bank B is written only by port 1
	laneElem bankB [regCount];

	// Set when bank B holds the current value of a register
	logic [regCount-1:0] liveB;

	// ==========================================================
	// Write side
	// ==========================================================

	// Each port writes its own bank and points the live bit at it
	// The arbiter keeps the two ports off the same register in a lane
	always_ff @(posedge clk) begin
		if (reset) begin
			liveB <= '0;
			for (int r = 0; r < regCount; r++) begin
				bankA[r] <= '0;
				bankB[r] <= '0;
			end
		end else begin
			if (op0 != opKeep) begin
				bankA[wa0] <= opValue(op0, i0);
				liveB[wa0] <= 1'b0;
			end
			if (op1 != opKeep) begin
				bankB[wa1] <= opValue(op1, i1);
				liveB[wa1] <= 1'b1;
			end
		end
	end

	// ==========================================================
	// Read side
	// ==========================================================

	// Every read port picks the bank that the live bit names
	always_comb begin
		for (int p = 0; p < readPortCount; p++) begin
			if (liveB[readAddr[p]])
				rawData[p] = bankB[readAddr[p]];
			else
				rawData[p] = bankA[readAddr[p]];
		end
	end

	// Two writes to one register in one lane would leave the live bit ambiguous
	// The arbiter upstream is what rules this out
	laneWriteNoClash : assert property (
		@(posedge clk) disable iff (reset)
		!(op0 != opKeep && op1 != opKeep && wa0 == wa1)
	) else $error("vecLaneBank: both ports write register %0d", wa0);

endmodule

// ==== hdl/vecReadBypass.sv ====
// ==========================================================
// Read bypass for the vector register file
// Forms the final read data of all eight ports from the raw
// bank reads, forwarding the writes of the current cycle
// with port 1 first, and forcing register 0 to zero
// Purely combinational
// ==========================================================

`timescale 1ns/1ps

module vecReadBypass (
	input vecGeomPkg::readAddrVec readAddr,
	input vecGeomPkg::laneElem [vecGeomPkg::laneCount-1:0][vecGeomPkg::readPortCount-1:0] laneRaw,
	input vecWritePkg::laneOpVec op0,
	input vecWritePkg::laneOpVec op1,
	input vecGeomPkg::regAddr wa0,
	input vecGeomPkg::regAddr wa1,
	input vecGeomPkg::vecWord i0,
	input vecGeomPkg::vecWord i1,
	output vecGeomPkg::readDataVec readData
);
	import vecGeomPkg::*;
	import vecWritePkg::*;

	// ==========================================================
	// Per-port, per-lane select
	// ==========================================================

	// Register 0 is hardwired to zero and wins over everything
	// Port 1 is checked before port 0 so the arbiter's priority holds here too
	// An op of opKeep never forwards, so masked-off lanes fall through to storage
	always_comb begin
		for (int p = 0; p < readPortCount; p++) begin
			for (int l = 0; l < laneCount; l++) begin
				if (readAddr[p] == '0)
					readData[p][l] = '0;
				else if (op1[l] != opKeep && readAddr[p] == wa1)
					readData[p][l] = opValue(op1[l], i1[l]);
				else if (op0[l] != opKeep && readAddr[p] == wa0)
					readData[p][l] = opValue(op0[l], i0[l]);
				else
					readData[p][l] = laneRaw[l][p];
			end
		end
	end

	// An unknown address would select unknown storage on every lane at once
	always_comb begin
		assert final (!$isunknown(readAddr))
			else $error("vecReadBypass: read address has unknown bits");
	end

endmodule

// ==== hdl/vecRegFile.sv ====
// ==========================================================
// Vector register file, top level
// 32 registers of 4 lanes, two masked write ports with a
// zero flag each, and eight combinational read ports
// Writes land at the rising clock edge, reads of the same
// cycle see them through the bypass
// ==========================================================

`timescale 1ns/1ps

module vecRegFile (
	input logic clk,
	input logic reset,
	input logic wr0,
	input vecGeomPkg::regAddr wa0,
	input vecGeomPkg::laneMask m0,
	input logic z0,
	input vecGeomPkg::vecWord i0,
	input logic wr1,
	input vecGeomPkg::regAddr wa1,
	input vecGeomPkg::laneMask m1,
	input logic z1,
	input vecGeomPkg::vecWord i1,
	input vecGeomPkg::readAddrVec readAddr,
	output vecGeomPkg::readDataVec readData
);
	import vecGeomPkg::*;
	import vecWritePkg::*;

	// Per-lane operations after conflict resolution
	laneOpVec op0;
	laneOpVec op1;

	// Raw storage reads, indexed by lane and then by read port
	laneElem [laneCount-1:0][readPortCount-1:0] laneRaw;

	vecWriteArbiter arbiter (
		.wr0(wr0),
		.wr1(wr1),
		.wa0(wa0),
		.wa1(wa1),
		.m0(m0),
		.m1(m1),
		.z0(z0),
		.z1(z1),
		.op0(op0),
		.op1(op1)
	);

	// One storage slice per lane, each with its own pair of banks
	for (genvar g = 0; g < laneCount; g++) begin : gLane
		vecLaneBank bank (
			.clk(clk),
			.reset(reset),
			.op0(op0[g]),
			.op1(op1[g]),
			.wa0(wa0),
			.wa1(wa1),
			.i0(i0[g]),
			.i1(i1[g]),
			.readAddr(readAddr),
			.rawData(laneRaw[g])
		);
	end

	vecReadBypass bypass (
		.readAddr(readAddr),
		.laneRaw(laneRaw),
		.op0(op0),
		.op1(op1),
		.wa0(wa0),
		.wa1(wa1),
		.i0(i0),
		.i1(i1),
		.readData(readData)
	);

endmodule

// ==== hdl/vecWriteArbiter.sv ====
// ==========================================================
// Write arbiter for the two vector write ports
// Turns strobes, lane masks and zero flags into per-lane
// operations, and gives port 1 priority per lane when both
// ports target the same register
// Purely combinational
// ==========================================================

`timescale 1ns/1ps

module vecWriteArbiter (
	input logic wr0,
	input logic wr1,
	input vecGeomPkg::regAddr wa0,
	input vecGeomPkg::regAddr wa1,
	input vecGeomPkg::laneMask m0,
	input vecGeomPkg::laneMask m1,
	input logic z0,
	input logic z1,
	output vecWritePkg::laneOpVec op0,
	output vecWritePkg::laneOpVec op1
);
	import vecGeomPkg::*;
	import vecWritePkg::*;

	// Port 0 operations before the conflict rule is applied
	laneOpVec raw0;

	// Both ports name the same register this cycle
	logic sameAddr;

	// A masked lane takes the port data
	// An unmasked lane is cleared only when the zero flag is set
	function automatic laneOp decodeLane(
		input logic wr,
		input logic maskBit,
		input logic zero
	);
		if (!wr)
			return opKeep;
		if (maskBit)
			return opData;
		if (zero)
			return opZero;
		return opKeep;
	endfunction

	assign sameAddr = (wa0 == wa1);

	// ==========================================================
	// Per-lane decode
	// ==========================================================

	always_comb begin
		for (int l = 0; l < laneCount; l++) begin
			raw0[l] = decodeLane(wr0, m0[l], z0);
			op1[l] = decodeLane(wr1, m1[l], z1);
		end
	end

	// Port 0 steps back in every lane where port 1 acts on the same register
	// Lanes that port 1 leaves alone still take the port 0 result
	always_comb begin
		for (int l = 0; l < laneCount; l++) begin
			op0[l] = (sameAddr && op1[l] != opKeep) ? opKeep : raw0[l];
		end
	end

endmodule

// ==== hdl/vecWritePkg.sv ====
// ==========================================================
// Per-lane write operations
// The arbiter turns strobes, masks and zero flags into one
// operation per lane and port, and the banks and the read
// bypass act on those operations
// ==========================================================

package vecWritePkg;

	// What one write port does to one lane this cycle
	typedef enum logic [1:0] {
		opKeep = 2'd0,
		opData = 2'd1,
		opZero = 2'd2
	} laneOp;

	// One operation per lane, lane 0 in the low bits
	typedef laneOp [vecGeomPkg::laneCount-1:0] laneOpVec;

	// Value that an active operation stores in a lane
	// The caller only uses the result when the op is not opKeep
	function automatic vecGeomPkg::laneElem opValue(
		input laneOp op,
		input vecGeomPkg::laneElem data
	);
		return (op == opData) ? data : '0;
	endfunction

endpackage
